// File: project.f
logic/sieve_pkg.sv
logic/sieve_cfg_if.sv
logic/sieve_config_memory.sv
logic/sieve_packet_fifo.sv
logic/sieve_generator.sv
logic/engine_sieve.sv
sim/engine_sieve_assert.sv
sim/tb_engine_sieve.sv

// File: Bender.yml
package:
  name: engine_sieve

sources:
  - logic/sieve_pkg.sv
  - logic/sieve_cfg_if.sv
  - logic/sieve_config_memory.sv
  - logic/sieve_packet_fifo.sv
  - logic/sieve_generator.sv
  - logic/engine_sieve.sv
  - target: simulation
    files:
      - sim/engine_sieve_assert.sv
      - sim/tb_engine_sieve.sv

// File: sim/tb_engine_sieve.sv
`timescale 1ns/100ps

module tb_engine_sieve;

    // ------------------------------
    // Run sizes and watchdog
    // ------------------------------

    localparam int RUN_PKTS    = 48;
    localparam int STALL_PKTS  = 40;
    localparam int NUM_RUNS    = 5;
    localparam int TOTAL_PKTS  = STALL_PKTS + 4 * RUN_PKTS;
    // Eight cycles per packet plus reset and setup overhead per run
    localparam int CYCLE_LIMIT = TOTAL_PKTS * 8 + NUM_RUNS * 150;

    logic                 ap_clk;
    logic                 areset_alu_ops_engine;
    logic                 descriptor_valid;
    sieve_pkg::count_t    descriptor_count;
    logic                 mem_resp_valid;
    sieve_pkg::cfg_addr_t mem_resp_addr;
    sieve_pkg::data_t     mem_resp_data;
    logic                 engine_in_valid;
    sieve_pkg::data_t     engine_in_data;
    sieve_pkg::tag_t      engine_in_tag;
    logic                 engine_in_prog_full;
    logic                 request_valid;
    sieve_pkg::data_t     request_data;
    sieve_pkg::tag_t      request_tag;
    logic                 request_rd_en;
    logic                 fifo_setup_signal;
    logic                 done_out;

    // Scoreboard, passing packets in arrival order
    sieve_pkg::data_t exp_data_q[$];
    sieve_pkg::tag_t  exp_tag_q[$];
    int sent_count;
    int desc_count;
    int cycle_count;
    bit run_active;
    bit consumer_stall;
    bit saw_prog_full;

    // Buffer occupancy model
    // A passing packet lands in the buffer three cycles after it is presented
    bit       in_pass;
    bit [2:0] pass_pipe;
    int       model_count;

    engine_sieve dut0 (
        .ap_clk               (ap_clk),
        .areset_alu_ops_engine(areset_alu_ops_engine),
        .descriptor_valid     (descriptor_valid),
        .descriptor_count     (descriptor_count),
        .mem_resp_valid       (mem_resp_valid),
        .mem_resp_addr        (mem_resp_addr),
        .mem_resp_data        (mem_resp_data),
        .engine_in_valid      (engine_in_valid),
        .engine_in_data       (engine_in_data),
        .engine_in_tag        (engine_in_tag),
        .engine_in_prog_full  (engine_in_prog_full),
        .request_valid        (request_valid),
        .request_data         (request_data),
        .request_tag          (request_tag),
        .request_rd_en        (request_rd_en),
        .fifo_setup_signal    (fifo_setup_signal),
        .done_out             (done_out)
    );

    always #10 ap_clk = ~ap_clk;

    // ------------------------------
    // Reference and reporting
    // ------------------------------

    // Filter rule as specified for the engine
    function automatic bit expected_pass(
        input sieve_pkg::filter_op_e op,
        input sieve_pkg::data_t      operand,
        input sieve_pkg::data_t      mask,
        input sieve_pkg::data_t      data
    );
        if (op == sieve_pkg::op_less_than) begin
            return data < operand;
        end
        if (op == sieve_pkg::op_greater_equal) begin
            return data >= operand;
        end
        if (op == sieve_pkg::op_masked_equal) begin
            return (data & mask) == (operand & mask);
        end
        return 1'b1;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    // Nothing may leave the engine before it runs
    task automatic check_idle(input string phase);
        check_value({"fifo_setup_signal ", phase}, fifo_setup_signal, 1);
        check_value({"done_out ", phase}, done_out, 0);
        check_value({"request_valid ", phase}, request_valid, 0);
    endtask

    // ------------------------------
    // Stimulus tasks, entered right after a falling edge
    // ------------------------------

    task automatic apply_reset();
        run_active            = 1'b0;
        areset_alu_ops_engine = 1'b1;
        descriptor_valid      = 1'b0;
        mem_resp_valid        = 1'b0;
        engine_in_valid       = 1'b0;
        repeat (16) @(negedge ap_clk);
        areset_alu_ops_engine = 1'b0;
        exp_data_q.delete();
        exp_tag_q.delete();
        sent_count  = 0;
        model_count = 0;
        pass_pipe   = '0;
        // Registered reset copies lag by one cycle
        repeat (2) @(negedge ap_clk);
        run_active = 1'b1;
    endtask

    task automatic write_config(input sieve_pkg::cfg_addr_t addr, input sieve_pkg::data_t data);
        mem_resp_valid = 1'b1;
        mem_resp_addr  = addr;
        mem_resp_data  = data;
        @(negedge ap_clk);
        mem_resp_valid = 1'b0;
    endtask

    task automatic send_descriptor(input int count);
        desc_count       = count;
        descriptor_valid = 1'b1;
        descriptor_count = sieve_pkg::count_t'(count);
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
    endtask

    task automatic wait_setup_low();
        int waited;
        waited = 0;
        while (fifo_setup_signal) begin
            if (waited == 12) begin
                fail_run("fifo_setup_signal stayed high after commit and descriptor");
            end
            waited++;
            @(negedge ap_clk);
        end
    endtask

    task automatic send_packets(input sieve_pkg::filter_op_e op, input sieve_pkg::data_t operand,
                                input sieve_pkg::data_t mask, input int n);
        sieve_pkg::data_t data;
        for (int i = 0; i < n; i++) begin
            data = $urandom;
            // Hold off while the buffer reports back-pressure
            while (engine_in_prog_full) begin
                engine_in_valid = 1'b0;
                if (consumer_stall) begin
                    saw_prog_full  = 1'b1;
                    consumer_stall = 1'b0;
                end
                @(negedge ap_clk);
            end
            // Sixteen or more entries are held by now
            if (consumer_stall && i >= sieve_pkg::PROG_THRESH + 4) begin
                fail_run("engine_in_prog_full stayed low with the consumer stalled");
            end
            engine_in_valid = 1'b1;
            engine_in_data  = data;
            engine_in_tag   = sieve_pkg::tag_t'(i);
            in_pass         = expected_pass(op, operand, mask, data);
            if (in_pass) begin
                exp_data_q.push_back(data);
                exp_tag_q.push_back(sieve_pkg::tag_t'(i));
            end
            sent_count++;
            @(negedge ap_clk);
            // Occasional idle cycle
            if ($urandom_range(3) == 0) begin
                engine_in_valid = 1'b0;
                @(negedge ap_clk);
            end
        end
        engine_in_valid = 1'b0;
    endtask

    // One reset, configure, descriptor and packet stream
    task automatic run_rule(input sieve_pkg::filter_op_e op, input sieve_pkg::data_t operand,
                            input sieve_pkg::data_t mask, input int n, input bit desc_first,
                            input bit late_write, input bit stall);
        apply_reset();
        check_idle("after reset");
        if (desc_first) begin
            send_descriptor(n);
            repeat (4) @(negedge ap_clk);
            check_idle("with descriptor only");
        end
        write_config(sieve_pkg::CFG_ADDR_OP, sieve_pkg::data_t'(op));
        write_config(sieve_pkg::CFG_ADDR_OPERAND, operand);
        write_config(sieve_pkg::CFG_ADDR_MASK, mask);
        write_config(sieve_pkg::CFG_ADDR_COMMIT, '0);
        repeat (4) @(negedge ap_clk);
        if (!desc_first) begin
            check_idle("with configuration only");
            send_descriptor(n);
        end
        // Words after commit must be ignored
        if (late_write) begin
            write_config(sieve_pkg::CFG_ADDR_OP, sieve_pkg::data_t'(sieve_pkg::op_pass_all));
            write_config(sieve_pkg::CFG_ADDR_OPERAND, ~operand);
            write_config(sieve_pkg::CFG_ADDR_MASK, '0);
        end
        wait_setup_low();
        saw_prog_full  = 1'b0;
        consumer_stall = stall;
        send_packets(op, operand, mask, n);
        if (stall) begin
            check_value("engine_in_prog_full seen", saw_prog_full, 1);
        end
        while (!done_out) @(negedge ap_clk);
        check_value("packets left at done", exp_data_q.size(), 0);
        // Done holds until the next reset
        repeat (8) begin
            @(negedge ap_clk);
            check_value("done_out after done", done_out, 1);
        end
    endtask

    // ------------------------------
    // Consumer and compare
    // ------------------------------

    always @(negedge ap_clk) begin
        request_rd_en = !consumer_stall && ($urandom_range(3) != 0);
    end

    always @(posedge ap_clk) begin
        // Status flags follow the modelled occupancy
        if (run_active) begin
            check_value("request_valid", request_valid, model_count != 0);
            check_value("engine_in_prog_full", engine_in_prog_full,
                        model_count >= sieve_pkg::PROG_THRESH);
        end
        if (run_active && request_valid && request_rd_en) begin
            if (exp_data_q.size() == 0) begin
                fail_run("request_valid high with no passing packet expected");
            end
            check_value("request_data", request_data, exp_data_q.pop_front());
            check_value("request_tag", request_tag, exp_tag_q.pop_front());
        end
        // Done only once all packets are in and read out
        if (run_active && done_out) begin
            check_value("sent packets at done_out", sent_count, desc_count);
            check_value("unread packets at done_out", exp_data_q.size(), 0);
        end
        // Pop sees the occupancy before this edge's write
        if (request_rd_en && model_count != 0) begin
            model_count--;
        end
        if (pass_pipe[2]) begin
            model_count++;
        end
        pass_pipe = {pass_pipe[1:0], engine_in_valid && in_pass};
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run("timeout, the engine did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(24344));
        ap_clk                = 1'b0;
        areset_alu_ops_engine = 1'b1;
        descriptor_valid      = 1'b0;
        descriptor_count      = '0;
        mem_resp_valid        = 1'b0;
        mem_resp_addr         = '0;
        mem_resp_data         = '0;
        engine_in_valid       = 1'b0;
        engine_in_data        = '0;
        engine_in_tag         = '0;
        request_rd_en         = 1'b0;
        run_active            = 1'b0;
        consumer_stall        = 1'b0;
        saw_prog_full         = 1'b0;
        in_pass               = 1'b0;
        pass_pipe             = '0;
        model_count           = 0;
        cycle_count           = 0;
        sent_count            = 0;
        desc_count            = 0;
        @(negedge ap_clk);
        run_rule(sieve_pkg::op_pass_all, '0, '0, STALL_PKTS, 1'b0, 1'b0, 1'b1);
        run_rule(sieve_pkg::op_less_than, 32'h4000_0000, '0, RUN_PKTS, 1'b1, 1'b0, 1'b0);
        run_rule(sieve_pkg::op_greater_equal, 32'ha000_0000, '0, RUN_PKTS, 1'b0, 1'b0, 1'b0);
        run_rule(sieve_pkg::op_masked_equal, 32'h0000_0001, 32'h0000_0003, RUN_PKTS,
                 1'b0, 1'b0, 1'b0);
        run_rule(sieve_pkg::op_less_than, 32'h2000_0000, '0, RUN_PKTS, 1'b0, 1'b1, 1'b0);
        $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_engine_sieve

// File: sim/engine_sieve_assert.sv
`timescale 1ns/100ps

module engine_sieve_assert (
    input logic ap_clk,
    input logic areset_alu_ops_engine,
    input logic areset_engine,
    input logic engine_in_valid,
    input logic fifo_setup_signal,
    input logic request_valid,
    input logic request_rd_en,
    input logic done_out
);

    // ------------------------------
    // Source and consumer protocol
    // ------------------------------

    // No packets until setup is over
    assert property (@(posedge ap_clk) disable iff (areset_alu_ops_engine || areset_engine)
        engine_in_valid |-> !fifo_setup_signal)
        else $error("engine packet presented while fifo_setup_signal is high");

    // Head entry only leaves through a pop
    assert property (@(posedge ap_clk) disable iff (areset_alu_ops_engine || areset_engine)
        (request_valid && !request_rd_en) |=> request_valid)
        else $error("request_valid fell without request_rd_en");

    // Sticky until reset
    assert property (@(posedge ap_clk) disable iff (areset_alu_ops_engine || areset_engine)
        done_out |=> done_out)
        else $error("done_out fell before reset");

endmodule : engine_sieve_assert

bind engine_sieve engine_sieve_assert u_engine_sieve_assert (
    .ap_clk               (ap_clk),
    .areset_alu_ops_engine(areset_alu_ops_engine),
    .areset_engine        (areset_engine),
    .engine_in_valid      (engine_in_valid),
    .fifo_setup_signal    (fifo_setup_signal),
    .request_valid        (request_valid),
    .request_rd_en        (request_rd_en),
    .done_out             (done_out)
);

// File: logic/engine_sieve.sv
`timescale 1ns/100ps

module engine_sieve (
    input  logic                 ap_clk,
    input  logic                 areset_alu_ops_engine,
    input  logic                 descriptor_valid,
    input  sieve_pkg::count_t    descriptor_count,
    input  logic                 mem_resp_valid,
    input  sieve_pkg::cfg_addr_t mem_resp_addr,
    input  sieve_pkg::data_t     mem_resp_data,
    input  logic                 engine_in_valid,
    input  sieve_pkg::data_t     engine_in_data,
    input  sieve_pkg::tag_t      engine_in_tag,
    output logic                 engine_in_prog_full,
    output logic                 request_valid,
    output sieve_pkg::data_t     request_data,
    output sieve_pkg::tag_t      request_tag,
    input  logic                 request_rd_en,
    output logic                 fifo_setup_signal,
    output logic                 done_out
);

    // Per-block reset copies
    logic areset_configure_memory;
    logic areset_generator;
    logic areset_engine;

    // Registered inputs
    logic                 descriptor_valid_reg;
    sieve_pkg::count_t    descriptor_count_reg;
    logic                 mem_resp_valid_reg;
    sieve_pkg::cfg_addr_t mem_resp_addr_reg;
    sieve_pkg::data_t     mem_resp_data_reg;
    logic                 engine_in_valid_reg;
    sieve_pkg::data_t     engine_in_data_reg;
    sieve_pkg::tag_t      engine_in_tag_reg;

    // Generator to buffer
    logic             pass_valid;
    sieve_pkg::data_t pass_data;
    sieve_pkg::tag_t  pass_tag;
    logic             generator_setup;
    logic             generator_done;
    logic             fifo_empty;

    sieve_cfg_if cfg_bus ();

    // ------------------------------
    // Reset copies
    // ------------------------------

    always_ff @(posedge ap_clk) begin
        areset_configure_memory <= areset_alu_ops_engine;
        areset_generator        <= areset_alu_ops_engine;
        areset_engine           <= areset_alu_ops_engine;
    end

    // ------------------------------
    // Input registers
    // ------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            descriptor_valid_reg <= 1'b0;
            mem_resp_valid_reg   <= 1'b0;
            engine_in_valid_reg  <= 1'b0;
        end else begin
            descriptor_valid_reg <= descriptor_valid;
            mem_resp_valid_reg   <= mem_resp_valid;
            engine_in_valid_reg  <= engine_in_valid;
        end
    end

    // Payload follows its valid, no reset
    always_ff @(posedge ap_clk) begin
        descriptor_count_reg <= descriptor_count;
        mem_resp_addr_reg    <= mem_resp_addr;
        mem_resp_data_reg    <= mem_resp_data;
        engine_in_data_reg   <= engine_in_data;
        engine_in_tag_reg    <= engine_in_tag;
    end

    // ------------------------------
    // Status outputs
    // ------------------------------

    // Done is sticky until reset
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            done_out          <= 1'b0;
            fifo_setup_signal <= 1'b1;
        end else begin
            done_out          <= done_out || (generator_done && fifo_empty);
            fifo_setup_signal <= generator_setup;
        end
    end

    // Request side shows the buffer head
    assign request_valid = !fifo_empty;

    sieve_config_memory inst_sieve_config_memory (
        .ap_clk        (ap_clk),
        .areset        (areset_configure_memory),
        .mem_resp_valid(mem_resp_valid_reg),
        .mem_resp_addr (mem_resp_addr_reg),
        .mem_resp_data (mem_resp_data_reg),
        .cfg           (cfg_bus.source)
    );

    sieve_generator inst_sieve_generator (
        .ap_clk          (ap_clk),
        .areset          (areset_generator),
        .cfg             (cfg_bus.sink),
        .descriptor_valid(descriptor_valid_reg),
        .descriptor_count(descriptor_count_reg),
        .pkt_valid       (engine_in_valid_reg),
        .pkt_data        (engine_in_data_reg),
        .pkt_tag         (engine_in_tag_reg),
        .pass_valid      (pass_valid),
        .pass_data       (pass_data),
        .pass_tag        (pass_tag),
        .setup           (generator_setup),
        .gen_done        (generator_done)
    );

    // Pops in the same cycle as request_rd_en
    sieve_packet_fifo #(
        .DEPTH(sieve_pkg::FIFO_DEPTH)
    ) inst_sieve_packet_fifo (
        .ap_clk   (ap_clk),
        .areset   (areset_engine),
        .wr_en    (pass_valid),
        .wr_data  (pass_data),
        .wr_tag   (pass_tag),
        .rd_en    (request_rd_en),
        .rd_data  (request_data),
        .rd_tag   (request_tag),
        .empty    (fifo_empty),
        .prog_full(engine_in_prog_full)
    );

endmodule : engine_sieve

// File: logic/sieve_generator.sv
`timescale 1ns/100ps

module sieve_generator (
    input  logic              ap_clk,
    input  logic              areset,
    sieve_cfg_if.sink         cfg,
    input  logic              descriptor_valid,
    input  sieve_pkg::count_t descriptor_count,
    input  logic              pkt_valid,
    input  sieve_pkg::data_t  pkt_data,
    input  sieve_pkg::tag_t   pkt_tag,
    output logic              pass_valid,
    output sieve_pkg::data_t  pass_data,
    output sieve_pkg::tag_t   pass_tag,
    output logic              setup,
    output logic              gen_done
);

    // Rule check for one data word
    function automatic logic filter_hit(
        input sieve_pkg::filter_op_e op,
        input sieve_pkg::data_t      operand,
        input sieve_pkg::data_t      mask,
        input sieve_pkg::data_t      data
    );
        logic hit;
        case (op)
            sieve_pkg::op_less_than:     hit = (data < operand);
            sieve_pkg::op_greater_equal: hit = (data >= operand);
            sieve_pkg::op_masked_equal:  hit = ((data & mask) == (operand & mask));
            default:                     hit = 1'b1;
        endcase
        return hit;
    endfunction

    // ------------------------------
    // Run control
    // ------------------------------

    sieve_pkg::gen_state_e state;
    sieve_pkg::count_t     expected_count;
    sieve_pkg::count_t     pkt_count;
    logic                  desc_seen;
    logic                  accept;

    // Stage one, rule result
    logic             s1_valid;
    logic             s1_hit;
    sieve_pkg::data_t s1_data;
    sieve_pkg::tag_t  s1_tag;

    // Stage two, passed packets only
    logic             s2_valid;
    sieve_pkg::data_t s2_data;
    sieve_pkg::tag_t  s2_tag;

    // Packets only taken while running
    assign accept = pkt_valid && (state == sieve_pkg::gen_run);

    // Descriptor may land before or after commit
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            desc_seen <= 1'b0;
        end else if (descriptor_valid && (state == sieve_pkg::gen_setup)) begin
            desc_seen <= 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (descriptor_valid && (state == sieve_pkg::gen_setup)) begin
            expected_count <= descriptor_count;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state     <= sieve_pkg::gen_setup;
            pkt_count <= '0;
        end else begin
            if (accept) begin
                pkt_count <= pkt_count + 1'b1;
            end
            case (state)
                sieve_pkg::gen_setup: begin
                    if (cfg.committed && desc_seen) begin
                        state <= sieve_pkg::gen_run;
                    end
                end
                sieve_pkg::gen_run: begin
                    // Last packet counted and drained out of both stages
                    if ((pkt_count == expected_count) && !s1_valid && !s2_valid) begin
                        state <= sieve_pkg::gen_done;
                    end
                end
                default: begin
                    // gen_done holds until reset
                    state <= sieve_pkg::gen_done;
                end
            endcase
        end
    end

    // ------------------------------
    // Filter pipeline
    // ------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid && s1_hit;
        end
    end

    always_ff @(posedge ap_clk) begin
        s1_hit  <= filter_hit(cfg.op, cfg.operand, cfg.mask, pkt_data);
        s1_data <= pkt_data;
        s1_tag  <= pkt_tag;
        s2_data <= s1_data;
        s2_tag  <= s1_tag;
    end

    assign pass_valid = s2_valid;
    assign pass_data  = s2_data;
    assign pass_tag   = s2_tag;

    // Status for the top level
    assign setup    = (state == sieve_pkg::gen_setup);
    assign gen_done = (state == sieve_pkg::gen_done);

endmodule : sieve_generator

// File: logic/sieve_packet_fifo.sv
`timescale 1ns/100ps

module sieve_packet_fifo #(
    parameter int DEPTH = 32
) (
    input  logic             ap_clk,
    input  logic             areset,
    input  logic             wr_en,
    input  sieve_pkg::data_t wr_data,
    input  sieve_pkg::tag_t  wr_tag,
    input  logic             rd_en,
    output sieve_pkg::data_t rd_data,
    output sieve_pkg::tag_t  rd_tag,
    output logic             empty,
    output logic             prog_full
);

    // Pointer width, count is one bit wider to hold DEPTH
    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);
    localparam logic [AW:0] PROG_CNT = (AW+1)'(sieve_pkg::PROG_THRESH);

    // Storage, no reset needed
    sieve_pkg::data_t data_mem [DEPTH];
    sieve_pkg::tag_t  tag_mem  [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    logic full;
    logic do_write;
    logic do_read;

    assign full     = (count == FULL_CNT);
    assign empty    = (count == '0);
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // ------------------------------
    // Storage write
    // ------------------------------

    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            data_mem[wr_ptr] <= wr_data;
            tag_mem[wr_ptr]  <= wr_tag;
        end
    end

    // Pointers wrap on their own at power-of-two depth
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry shows without a read, first-word fall-through
    assign rd_data = data_mem[rd_ptr];
    assign rd_tag  = tag_mem[rd_ptr];

    // Back-pressure level
    assign prog_full = (count >= PROG_CNT);

endmodule : sieve_packet_fifo

// File: logic/sieve_config_memory.sv
`timescale 1ns/100ps

module sieve_config_memory (
    input  logic                 ap_clk,
    input  logic                 areset,
    input  logic                 mem_resp_valid,
    input  sieve_pkg::cfg_addr_t mem_resp_addr,
    input  sieve_pkg::data_t     mem_resp_data,
    sieve_cfg_if.source          cfg
);

    // ------------------------------
    // Configuration registers
    // ------------------------------

    sieve_pkg::cfg_state_e state;
    sieve_pkg::filter_op_e op_q;
    sieve_pkg::data_t      operand_q;
    sieve_pkg::data_t      mask_q;

    // Words only land before commit
    logic write_en;

    assign write_en = mem_resp_valid && (state == sieve_pkg::cfg_unset);

    // Commit word locks the block until reset
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state <= sieve_pkg::cfg_unset;
        end else if (write_en && (mem_resp_addr == sieve_pkg::CFG_ADDR_COMMIT)) begin
            state <= sieve_pkg::cfg_committed;
        end
    end

    // Field writes by address
    always_ff @(posedge ap_clk) begin
        if (write_en) begin
            case (mem_resp_addr)
                sieve_pkg::CFG_ADDR_OP: begin
                    // Rule lives in the low two bits
                    op_q <= sieve_pkg::filter_op_e'(mem_resp_data[1:0]);
                end
                sieve_pkg::CFG_ADDR_OPERAND: begin
                    operand_q <= mem_resp_data;
                end
                sieve_pkg::CFG_ADDR_MASK: begin
                    mask_q <= mem_resp_data;
                end
                default: begin
                    // Commit word carries no field data
                end
            endcase
        end
    end

    // ------------------------------
    // Drive the configuration bus
    // ------------------------------

    assign cfg.op        = op_q;
    assign cfg.operand   = operand_q;
    assign cfg.mask      = mask_q;
    // Rises the cycle after the commit word is written
    assign cfg.committed = (state == sieve_pkg::cfg_committed);

endmodule : sieve_config_memory

// File: logic/sieve_cfg_if.sv
`timescale 1ns/100ps

interface sieve_cfg_if;

    // Filter rule selected by the op word
    sieve_pkg::filter_op_e op;
    // Compare value for the rule
    sieve_pkg::data_t operand;
    // Bit select for masked equal
    sieve_pkg::data_t mask;
    // Sticky, fields are frozen while high
    logic committed;

    // Configuration block side
    modport source (
        output op,
        output operand,
        output mask,
        output committed
    );

    // Generator side
    modport sink (
        input op,
        input operand,
        input mask,
        input committed
    );

endinterface : sieve_cfg_if

// File: logic/sieve_pkg.sv
package sieve_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------

    // Packet payload
    localparam int DATA_WIDTH = 32;
    // Packet identifier, carried along untouched
    localparam int TAG_WIDTH = 8;
    // Descriptor count and generator counter
    localparam int COUNT_WIDTH = 16;
    // Word select inside a configuration response
    localparam int CFG_ADDR_WIDTH = 2;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;
    typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;

    // ------------------------------
    // Filter rule
    // ------------------------------

    // Encoding matches the low 2 bits of the op configuration word
    typedef enum logic [1:0] {
        op_pass_all      = 2'd0,
        op_less_than     = 2'd1,
        op_greater_equal = 2'd2,
        op_masked_equal  = 2'd3
    } filter_op_e;

    // ------------------------------
    // State machines
    // ------------------------------

    // Configuration block, one-way after commit
    typedef enum logic {
        cfg_unset     = 1'b0,
        cfg_committed = 1'b1
    } cfg_state_e;

    // Generator run phases
    typedef enum logic [1:0] {
        gen_setup = 2'd0,
        gen_run   = 2'd1,
        gen_done  = 2'd2
    } gen_state_e;

    // Configuration word addresses
    localparam cfg_addr_t CFG_ADDR_OP      = 2'd0;
    localparam cfg_addr_t CFG_ADDR_OPERAND = 2'd1;
    localparam cfg_addr_t CFG_ADDR_MASK    = 2'd2;
    localparam cfg_addr_t CFG_ADDR_COMMIT  = 2'd3;

    // ------------------------------
    // Output buffer
    // ------------------------------

    // Entries in the passed-packet buffer, power of two
    localparam int FIFO_DEPTH = 32;
    // Back-pressure level, the rest of the depth absorbs packets in flight
    localparam int PROG_THRESH = 16;

endpackage : sieve_pkg
